// ==== Bender.yml ====
package:
  name: bus_interface_unit

sources:
  - include_dirs:
      - design
    files:
      - design/biu_pkg.sv
      - design/ifetch_port.sv
      - design/dmem_port.sv
      - design/axi_read_arbiter.sv
      - design/bus_interface_unit.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/axi_slave_model.sv
      - test/bus_interface_unit_tb.sv

// ==== design/axi_read_arbiter.sv ====
// round robin arbiter sharing the single AXI read channel between fetch and data ports

`timescale 1ns/1ps
`default_nettype none

`include "biu_defines.svh"

module axi_read_arbiter import biu_pkg::*; (
    input  logic    aclk,
    input  logic    reset,
    input  logic    inst_rd_req_valid,
    input  addr_t   inst_rd_req_addr,
    output logic    inst_rd_req_ready,
    output logic    inst_rd_resp_valid,
    output word_t   inst_rd_resp_data,
    input  logic    inst_rd_resp_ready,
    input  logic    data_rd_req_valid,
    input  addr_t   data_rd_req_addr,
    output logic    data_rd_req_ready,
    output logic    data_rd_resp_valid,
    output word_t   data_rd_resp_data,
    input  logic    data_rd_resp_ready,
    output logic    arvalid,
    output addr_t   araddr,
    output axi_id_t arid,
    input  logic    arready,
    input  logic    rvalid,
    input  word_t   rdata,
    input  axi_id_t rid,
    output logic    rready
);

    grant_t owner;           // port with a read in flight
    logic   last_data_won;   // winner of the last contest
    logic   hold_valid;      // AR waiting on arready
    logic   hold_inst;
    logic   both_req;
    logic   sel_inst;
    logic   ar_fire;

    assign both_req = inst_rd_req_valid && data_rd_req_valid;

    // a stalled AR keeps its port so araddr cannot change under it
    always_comb begin
        if (hold_valid) sel_inst = hold_inst;
        else if (both_req) sel_inst = last_data_won;
        else sel_inst = inst_rd_req_valid;
    end

    assign arvalid = (owner == grant_none) && (inst_rd_req_valid || data_rd_req_valid);
    assign araddr  = sel_inst ? inst_rd_req_addr : data_rd_req_addr;
    assign arid    = sel_inst ? axi_id_t'(`AXI_ID_INST) : axi_id_t'(`AXI_ID_DATA);
    assign ar_fire = arvalid && arready;

    assign inst_rd_req_ready = ar_fire && sel_inst;
    assign data_rd_req_ready = ar_fire && !sel_inst;

    // R goes only to the owner
    assign inst_rd_resp_valid = rvalid && (owner == grant_inst);
    assign data_rd_resp_valid = rvalid && (owner == grant_data);
    assign inst_rd_resp_data  = rdata;
    assign data_rd_resp_data  = rdata;
    assign rready = (owner == grant_inst) ? inst_rd_resp_ready :
                    (owner == grant_data) ? data_rd_resp_ready : 1'b0;

    always_ff @(posedge aclk) begin
        if (reset) begin
            owner         <= grant_none;
            last_data_won <= 1'b0;   // data takes the first contest
            hold_valid    <= 1'b0;
            hold_inst     <= 1'b0;
        end else begin
            if (ar_fire) begin
                owner      <= sel_inst ? grant_inst : grant_data;
                hold_valid <= 1'b0;
                if (both_req) last_data_won <= !sel_inst;
            end else if (arvalid) begin
                hold_valid <= 1'b1;
                hold_inst  <= sel_inst;
            end
            if (rvalid && rready) owner <= grant_none;
        end
    end

    a_no_orphan_r: assert property (@(posedge aclk) disable iff (reset)
        rvalid |-> owner != grant_none);

    // slave must echo the ID of the granted port
    a_rid_match: assert property (@(posedge aclk) disable iff (reset)
        rvalid |-> rid == ((owner == grant_inst) ? axi_id_t'(`AXI_ID_INST)
                                                 : axi_id_t'(`AXI_ID_DATA)));

endmodule

`default_nettype wire

// ==== design/biu_defines.svh ====
// bus interface unit widths and AXI read IDs shared by the package and the arbiter

`ifndef BIU_DEFINES_SVH
`define BIU_DEFINES_SVH

// data and address width
`define WORD_WIDTH 32

// one enable bit per byte of a word
`define STRB_WIDTH 4

// AXI ID field width
`define AXI_ID_WIDTH 4

// read IDs tag which port owns an AR transaction
`define AXI_ID_INST 0
`define AXI_ID_DATA 1

`endif

// ==== design/biu_pkg.sv ====
// bus interface unit package with the shared vector types and FSM state encodings

`default_nettype none

`include "biu_defines.svh"

package biu_pkg;

    typedef logic [`WORD_WIDTH-1:0]   word_t;   // data word
    typedef logic [`WORD_WIDTH-1:0]   addr_t;   // byte address
    typedef logic [`STRB_WIDTH-1:0]   strb_t;   // byte enables
    typedef logic [`AXI_ID_WIDTH-1:0] axi_id_t;

    // fetch port FSM
    typedef enum logic [1:0] {
        fetch_idle,
        fetch_addr,
        fetch_data
    } fetch_state_t;

    // data port FSM, read and write paths
    typedef enum logic [2:0] {
        dmem_idle,
        dmem_rd_addr,
        dmem_rd_data,
        dmem_wr_send,
        dmem_wr_resp
    } dmem_state_t;

    // current owner of the shared read channel
    typedef enum logic [1:0] {
        grant_none,
        grant_inst,
        grant_data
    } grant_t;

endpackage

`default_nettype wire

// ==== design/bus_interface_unit.sv ====
// bus interface unit top joining the fetch and data ports to one AXI master

`timescale 1ns/1ps
`default_nettype none

module bus_interface_unit import biu_pkg::*; (
    input  logic    aclk,
    input  logic    reset,
    // CPU fetch side
    input  logic    inst_req,
    input  addr_t   inst_addr,
    output logic    inst_busy,
    output logic    inst_valid,
    output word_t   inst_rdata,
    // CPU data side
    input  logic    data_req,
    input  logic    data_wr,
    input  addr_t   data_addr,
    input  word_t   data_wdata,
    input  strb_t   data_wstrb,
    output logic    data_busy,
    output logic    data_valid,
    output word_t   data_rdata,
    // AXI read channels
    output logic    arvalid,
    output addr_t   araddr,
    output axi_id_t arid,
    input  logic    arready,
    input  logic    rvalid,
    input  word_t   rdata,
    input  axi_id_t rid,
    output logic    rready,
    // AXI write channels, data port only
    output logic    awvalid,
    output addr_t   awaddr,
    input  logic    awready,
    output logic    wvalid,
    output word_t   wdata,
    output strb_t   wstrb,
    input  logic    wready,
    input  logic    bvalid,
    output logic    bready
);

    logic  inst_rd_req_valid;
    addr_t inst_rd_req_addr;
    logic  inst_rd_req_ready;
    logic  inst_rd_resp_valid;
    word_t inst_rd_resp_data;
    logic  inst_rd_resp_ready;
    logic  data_rd_req_valid;
    addr_t data_rd_req_addr;
    logic  data_rd_req_ready;
    logic  data_rd_resp_valid;
    word_t data_rd_resp_data;
    logic  data_rd_resp_ready;

    ifetch_port u_ifetch_port (
        .aclk          (aclk),
        .reset         (reset),
        .inst_req      (inst_req),
        .inst_addr     (inst_addr),
        .inst_busy     (inst_busy),
        .inst_valid    (inst_valid),
        .inst_rdata    (inst_rdata),
        .rd_req_valid  (inst_rd_req_valid),
        .rd_req_addr   (inst_rd_req_addr),
        .rd_req_ready  (inst_rd_req_ready),
        .rd_resp_valid (inst_rd_resp_valid),
        .rd_resp_data  (inst_rd_resp_data),
        .rd_resp_ready (inst_rd_resp_ready)
    );

    dmem_port u_dmem_port (
        .aclk          (aclk),
        .reset         (reset),
        .data_req      (data_req),
        .data_wr       (data_wr),
        .data_addr     (data_addr),
        .data_wdata    (data_wdata),
        .data_wstrb    (data_wstrb),
        .data_busy     (data_busy),
        .data_valid    (data_valid),
        .data_rdata    (data_rdata),
        .rd_req_valid  (data_rd_req_valid),
        .rd_req_addr   (data_rd_req_addr),
        .rd_req_ready  (data_rd_req_ready),
        .rd_resp_valid (data_rd_resp_valid),
        .rd_resp_data  (data_rd_resp_data),
        .rd_resp_ready (data_rd_resp_ready),
        .awvalid       (awvalid),
        .awaddr        (awaddr),
        .awready       (awready),
        .wvalid        (wvalid),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .wready        (wready),
        .bvalid        (bvalid),
        .bready        (bready)
    );

    axi_read_arbiter u_axi_read_arbiter (
        .aclk               (aclk),
        .reset              (reset),
        .inst_rd_req_valid  (inst_rd_req_valid),
        .inst_rd_req_addr   (inst_rd_req_addr),
        .inst_rd_req_ready  (inst_rd_req_ready),
        .inst_rd_resp_valid (inst_rd_resp_valid),
        .inst_rd_resp_data  (inst_rd_resp_data),
        .inst_rd_resp_ready (inst_rd_resp_ready),
        .data_rd_req_valid  (data_rd_req_valid),
        .data_rd_req_addr   (data_rd_req_addr),
        .data_rd_req_ready  (data_rd_req_ready),
        .data_rd_resp_valid (data_rd_resp_valid),
        .data_rd_resp_data  (data_rd_resp_data),
        .data_rd_resp_ready (data_rd_resp_ready),
        .arvalid            (arvalid),
        .araddr             (araddr),
        .arid               (arid),
        .arready            (arready),
        .rvalid             (rvalid),
        .rdata              (rdata),
        .rid                (rid),
        .rready             (rready)
    );

endmodule

`default_nettype wire

// ==== design/dmem_port.sv ====
// data memory port that turns load and store strobes into AXI reads or writes

`timescale 1ns/1ps
`default_nettype none

module dmem_port import biu_pkg::*; (
    input  logic  aclk,
    input  logic  reset,
    input  logic  data_req,
    input  logic  data_wr,
    input  addr_t data_addr,
    input  word_t data_wdata,
    input  strb_t data_wstrb,
    output logic  data_busy,
    output logic  data_valid,
    output word_t data_rdata,
    output logic  rd_req_valid,
    output addr_t rd_req_addr,
    input  logic  rd_req_ready,
    input  logic  rd_resp_valid,
    input  word_t rd_resp_data,
    output logic  rd_resp_ready,
    output logic  awvalid,
    output addr_t awaddr,
    input  logic  awready,
    output logic  wvalid,
    output word_t wdata,
    output strb_t wstrb,
    input  logic  wready,
    input  logic  bvalid,
    output logic  bready
);

    dmem_state_t state;
    addr_t       addr_q;
    word_t       wdata_q;
    strb_t       wstrb_q;
    logic        aw_done;   // AW accepted in this write
    logic        w_done;    // W accepted in this write
    logic        aw_ok;
    logic        w_ok;

    // either already accepted or accepted this cycle
    assign aw_ok = aw_done || awready;
    assign w_ok  = w_done || wready;

    always_ff @(posedge aclk) begin
        if (reset) begin
            state      <= dmem_idle;
            data_valid <= 1'b0;
            aw_done    <= 1'b0;
            w_done     <= 1'b0;
        end else begin
            data_valid <= 1'b0;
            case (state)
                dmem_idle: begin
                    if (data_req) state <= data_wr ? dmem_wr_send : dmem_rd_addr;
                end
                dmem_rd_addr: begin
                    if (rd_req_ready) state <= dmem_rd_data;
                end
                dmem_rd_data: begin
                    if (rd_resp_valid) begin
                        state      <= dmem_idle;
                        data_valid <= 1'b1;
                    end
                end
                dmem_wr_send: begin
                    if (aw_ok && w_ok) begin
                        state   <= dmem_wr_resp;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                    end else begin
                        aw_done <= aw_ok;
                        w_done  <= w_ok;
                    end
                end
                dmem_wr_resp: begin
                    if (bvalid) begin
                        state      <= dmem_idle;
                        data_valid <= 1'b1;   // write response completes the store
                    end
                end
                default: state <= dmem_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state == dmem_idle && data_req) begin
            addr_q  <= data_addr;
            wdata_q <= data_wdata;
            wstrb_q <= data_wstrb;
        end
        if (rd_resp_valid && rd_resp_ready) data_rdata <= rd_resp_data;
    end

    assign data_busy     = (state != dmem_idle);
    assign rd_req_valid  = (state == dmem_rd_addr);
    assign rd_req_addr   = addr_q;
    assign rd_resp_ready = (state == dmem_rd_data);
    assign awvalid       = (state == dmem_wr_send) && !aw_done;
    assign wvalid        = (state == dmem_wr_send) && !w_done;
    assign awaddr        = addr_q;
    assign wdata         = wdata_q;
    assign wstrb         = wstrb_q;
    assign bready        = (state == dmem_wr_resp);

    a_no_req_while_busy: assert property (@(posedge aclk) disable iff (reset)
        data_req |-> !data_busy);

    // a store must enable at least one byte
    a_wr_strb_nonzero: assert property (@(posedge aclk) disable iff (reset)
        data_req && data_wr |-> data_wstrb != '0);

    a_aw_stable: assert property (@(posedge aclk) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(awaddr));

    a_w_stable: assert property (@(posedge aclk) disable iff (reset)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb));

endmodule

`default_nettype wire

// ==== design/ifetch_port.sv ====
// instruction fetch port that turns fetch strobes into single-word AXI read requests

`timescale 1ns/1ps
`default_nettype none

module ifetch_port import biu_pkg::*; (
    input  logic  aclk,
    input  logic  reset,
    input  logic  inst_req,
    input  addr_t inst_addr,
    output logic  inst_busy,
    output logic  inst_valid,
    output word_t inst_rdata,
    output logic  rd_req_valid,
    output addr_t rd_req_addr,
    input  logic  rd_req_ready,
    input  logic  rd_resp_valid,
    input  word_t rd_resp_data,
    output logic  rd_resp_ready
);

    fetch_state_t state;
    addr_t        addr_q;   // fetch address held for the whole transaction

    always_ff @(posedge aclk) begin
        if (reset) begin
            state      <= fetch_idle;
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= 1'b0;
            case (state)
                fetch_idle: begin
                    if (inst_req) state <= fetch_addr;
                end
                fetch_addr: begin
                    if (rd_req_ready) state <= fetch_data;   // AR accepted
                end
                fetch_data: begin
                    if (rd_resp_valid) begin
                        state      <= fetch_idle;
                        inst_valid <= 1'b1;   // same cycle busy drops
                    end
                end
                default: state <= fetch_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state == fetch_idle && inst_req) addr_q <= inst_addr;
        if (rd_resp_valid && rd_resp_ready) inst_rdata <= rd_resp_data;
    end

    assign inst_busy     = (state != fetch_idle);
    assign rd_req_valid  = (state == fetch_addr);
    assign rd_req_addr   = addr_q;
    assign rd_resp_ready = (state == fetch_data);

    // CPU must wait for busy to clear before the next fetch
    a_no_req_while_busy: assert property (@(posedge aclk) disable iff (reset)
        inst_req |-> !inst_busy);

    a_addr_aligned: assert property (@(posedge aclk) disable iff (reset)
        inst_req |-> inst_addr[1:0] == 2'b00);

    // request held until the arbiter takes it
    a_req_stable: assert property (@(posedge aclk) disable iff (reset)
        rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_req_addr));

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+design
design/biu_pkg.sv
design/ifetch_port.sv
design/dmem_port.sv
design/axi_read_arbiter.sv
design/bus_interface_unit.sv
test/axi_slave_model.sv
test/bus_interface_unit_tb.sv

// ==== test/axi_slave_model.sv ====
// single-beat AXI memory model with pseudo-random ready and valid stalls

`timescale 1ns/1ps
`default_nettype none

module axi_slave_model import biu_pkg::*; (
    input  logic    aclk,
    input  logic    reset,
    input  logic    stall_en,       // 0 to 3 wait cycles when high
    input  word_t   fill_pattern,
    input  logic    arvalid,
    input  addr_t   araddr,
    input  axi_id_t arid,
    output logic    arready,
    output logic    rvalid,
    output word_t   rdata,
    output axi_id_t rid,
    input  logic    rready,
    input  logic    awvalid,
    input  addr_t   awaddr,
    output logic    awready,
    input  logic    wvalid,
    input  word_t   wdata,
    input  strb_t   wstrb,
    output logic    wready,
    output logic    bvalid,
    input  logic    bready
);

    word_t       mem [256];
    logic [31:0] rng;
    logic [1:0]  ar_cnt, r_cnt, aw_cnt, w_cnt;
    logic        r_pending;
    logic        aw_got;
    logic        w_got;
    addr_t       rd_addr_q, wr_addr_q;
    axi_id_t     rd_id_q;
    word_t       wr_data_q;
    strb_t       wr_strb_q;
    word_t       merged;
    int          i;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // advances the generator on every call
    function automatic logic [1:0] next_stall();
        rng = xorshift(rng);
        return stall_en ? rng[1:0] : 2'd0;
    endfunction

    always @(posedge aclk) begin
        if (reset) begin
            rng = 32'd75;
            for (i = 0; i < 256; i++) begin
                mem[i] <= word_t'(i * 4) ^ fill_pattern;   // byte address based fill
            end
            arready   <= 1'b0;
            rvalid    <= 1'b0;
            rdata     <= '0;
            rid       <= '0;
            awready   <= 1'b0;
            wready    <= 1'b0;
            bvalid    <= 1'b0;
            r_pending <= 1'b0;
            aw_got    <= 1'b0;
            w_got     <= 1'b0;
            ar_cnt    <= 2'd0;
            r_cnt     <= 2'd0;
            aw_cnt    <= 2'd0;
            w_cnt     <= 2'd0;
        end else begin
            if (arvalid && arready) begin
                arready   <= 1'b0;
                rd_addr_q <= araddr;
                rd_id_q   <= arid;
                r_pending <= 1'b1;
                r_cnt     <= next_stall();
                ar_cnt    <= next_stall();
            end else if (arvalid && !r_pending) begin
                if (ar_cnt == 2'd0) arready <= 1'b1;
                else ar_cnt <= ar_cnt - 2'd1;
            end
            if (rvalid && rready) begin
                rvalid    <= 1'b0;
                r_pending <= 1'b0;
            end else if (r_pending && !rvalid) begin
                if (r_cnt == 2'd0) begin
                    rvalid <= 1'b1;
                    rdata  <= mem[rd_addr_q[9:2]];
                    rid    <= rd_id_q;   // echo the granted port
                end else begin
                    r_cnt <= r_cnt - 2'd1;
                end
            end
            if (awvalid && awready) begin
                awready   <= 1'b0;
                aw_got    <= 1'b1;
                wr_addr_q <= awaddr;
                aw_cnt    <= next_stall();
            end else if (awvalid && !aw_got) begin
                if (aw_cnt == 2'd0) awready <= 1'b1;
                else aw_cnt <= aw_cnt - 2'd1;
            end
            if (wvalid && wready) begin
                wready    <= 1'b0;
                w_got     <= 1'b1;
                wr_data_q <= wdata;
                wr_strb_q <= wstrb;
                w_cnt     <= next_stall();
            end else if (wvalid && !w_got) begin
                if (w_cnt == 2'd0) wready <= 1'b1;
                else w_cnt <= w_cnt - 2'd1;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                aw_got <= 1'b0;
                w_got  <= 1'b0;
            end else if (aw_got && w_got && !bvalid) begin
                merged = mem[wr_addr_q[9:2]];
                for (i = 0; i < 4; i++) begin
                    if (wr_strb_q[i]) merged[8*i +: 8] = wr_data_q[8*i +: 8];
                end
                mem[wr_addr_q[9:2]] <= merged;
                bvalid <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/bus_interface_unit_tb.sv ====
// testbench for the bus interface unit with fetch, store, load, contention and stall tests

`timescale 1ns/1ps
`default_nettype none

`include "biu_defines.svh"

module bus_interface_unit_tb import biu_pkg::*; ();

    localparam word_t FILL_PATTERN = 32'h5EED_A5A5;
    localparam int    WAIT_LIMIT   = 200;   // cycles per operation

    logic    aclk, reset, stall_en;
    logic    inst_req, inst_busy, inst_valid;
    addr_t   inst_addr;
    word_t   inst_rdata;
    logic    data_req, data_wr, data_busy, data_valid;
    addr_t   data_addr;
    word_t   data_wdata, data_rdata;
    strb_t   data_wstrb;
    logic    arvalid, arready, rvalid, rready;
    addr_t   araddr;
    axi_id_t arid, rid;
    word_t   rdata;
    logic    awvalid, awready, wvalid, wready, bvalid, bready;
    addr_t   awaddr;
    word_t   wdata;
    strb_t   wstrb;

    word_t   exp_mem [256];   // expected slave memory image
    axi_id_t arid_log [$];    // arid at each AR handshake
    int      errors, checks, tests, test_errors;
    logic    prev_ar_wait, prev_aw_wait, prev_w_wait;
    addr_t   prev_araddr, prev_awaddr;
    word_t   prev_wdata;
    strb_t   prev_wstrb;

    bus_interface_unit dut (
        .aclk(aclk), .reset(reset),
        .inst_req(inst_req), .inst_addr(inst_addr), .inst_busy(inst_busy),
        .inst_valid(inst_valid), .inst_rdata(inst_rdata),
        .data_req(data_req), .data_wr(data_wr), .data_addr(data_addr),
        .data_wdata(data_wdata), .data_wstrb(data_wstrb), .data_busy(data_busy),
        .data_valid(data_valid), .data_rdata(data_rdata),
        .arvalid(arvalid), .araddr(araddr), .arid(arid), .arready(arready),
        .rvalid(rvalid), .rdata(rdata), .rid(rid), .rready(rready),
        .awvalid(awvalid), .awaddr(awaddr), .awready(awready),
        .wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wready(wready),
        .bvalid(bvalid), .bready(bready)
    );

    axi_slave_model mem_model (
        .aclk(aclk), .reset(reset), .stall_en(stall_en), .fill_pattern(FILL_PATTERN),
        .arvalid(arvalid), .araddr(araddr), .arid(arid), .arready(arready),
        .rvalid(rvalid), .rdata(rdata), .rid(rid), .rready(rready),
        .awvalid(awvalid), .awaddr(awaddr), .awready(awready),
        .wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wready(wready),
        .bvalid(bvalid), .bready(bready)
    );

    always #50 aclk = ~aclk;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            test_errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout: %s did not complete in %0d cycles", what, WAIT_LIMIT);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("%-14s %s", name, (test_errors == 0) ? "passed" : "failed");
        test_errors = 0;
    endtask

    // byte lanes with a set strobe bit take the new data
    function automatic word_t merge_bytes(input word_t old, input word_t data, input strb_t strb);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    // strobes the chosen ports in one cycle and follows both to their valid pulse
    task automatic run_ops(input string name, input logic do_inst, input addr_t iaddr,
                           input logic do_data, input logic wr, input addr_t daddr,
                           input word_t wdat, input strb_t strb);
        int    n;
        logic  inst_done;
        logic  data_done;
        word_t data_exp;
        n = 0;
        inst_done = !do_inst;
        data_done = !do_data;
        inst_req = do_inst;
        inst_addr = iaddr;
        data_req = do_data;
        data_wr = wr;
        data_addr = daddr;
        data_wdata = wdat;
        data_wstrb = strb;
        if (do_data && wr) exp_mem[daddr[9:2]] = merge_bytes(exp_mem[daddr[9:2]], wdat, strb);
        data_exp = exp_mem[daddr[9:2]];
        @(posedge aclk);
        #1;
        inst_req = 1'b0;
        data_req = 1'b0;
        while (!(inst_done && data_done) && n < WAIT_LIMIT) begin
            if (!inst_done) begin
                check_value(name, !inst_valid, inst_busy);   // busy drops with valid
                if (inst_valid) begin
                    check_value(name, exp_mem[iaddr[9:2]], inst_rdata);
                    inst_done = 1'b1;
                end
            end
            if (!data_done) begin
                check_value(name, !data_valid, data_busy);
                if (data_valid) begin
                    if (!wr) check_value(name, data_exp, data_rdata);
                    data_done = 1'b1;
                end
            end
            @(posedge aclk);
            #1;
            n++;
        end
        if (!(inst_done && data_done)) abort_on_timeout(name);
    endtask

    task automatic test_reset_state();
        // every status, valid and ready output idle
        check_value("reset_state", 0, {inst_busy, inst_valid, data_busy, data_valid,
                                       arvalid, rready, awvalid, wvalid, bready});
    endtask

    task automatic test_fetch();
        for (int i = 0; i < 6; i++) begin
            run_ops("fetch", 1'b1, addr_t'(32'h10 + 36 * i), 1'b0, 1'b0, '0, '0, '0);
        end
    endtask

    task automatic test_store_load();
        run_ops("store_full", 1'b0, '0, 1'b1, 1'b1, 32'h80, 32'h1122_3344, 4'b1111);
        run_ops("store_part", 1'b0, '0, 1'b1, 1'b1, 32'h80, 32'hAABB_CCDD, 4'b0101);
        run_ops("store_part", 1'b0, '0, 1'b1, 1'b1, 32'h80, 32'h5566_7788, 4'b1000);
        run_ops("load_merged", 1'b0, '0, 1'b1, 1'b0, 32'h80, '0, '0);
        check_value("load_merged", 32'h55BB_33DD, data_rdata);
    endtask

    task automatic test_contention();
        axi_id_t winner;
        axi_id_t loser;
        arid_log.delete();
        for (int r = 0; r < 4; r++) begin
            run_ops("contention", 1'b1, addr_t'(32'h100 + 4 * r),
                    1'b1, 1'b0, addr_t'(32'h180 + 4 * r), '0, '0);
        end
        check_value("contention", 8, arid_log.size());
        for (int r = 0; r < 4; r++) begin
            winner = (r % 2 == 0) ? axi_id_t'(`AXI_ID_DATA) : axi_id_t'(`AXI_ID_INST);
            loser = (r % 2 == 0) ? axi_id_t'(`AXI_ID_INST) : axi_id_t'(`AXI_ID_DATA);
            check_value("contention", winner, arid_log[2*r]);
            check_value("contention", loser, arid_log[2*r+1]);
        end
    endtask

    task automatic test_back_pressure();
        logic  wr;
        strb_t strb;
        word_t wdat;
        stall_en = 1'b1;
        for (int i = 0; i < 30; i++) begin
            wr = (i % 3) != 2;
            strb = strb_t'(i % 15 + 1);
            wdat = word_t'(32'h0101_0101 * i) ^ 32'hA5C3_0F69;
            // fetches stay out of the region the data port writes
            run_ops("back_pressure", 1'b1, addr_t'(32'h200 + 4 * (i % 16)),
                    1'b1, wr, addr_t'(32'h40 + 4 * (i % 8)), wdat, strb);
        end
        stall_en = 1'b0;
    endtask

    // mid-cycle monitor of held AR, AW and W channels
    always @(negedge aclk) begin
        if (reset) begin
            prev_ar_wait = 1'b0;
            prev_aw_wait = 1'b0;
            prev_w_wait = 1'b0;
        end else begin
            if (arvalid && arready) arid_log.push_back(arid);
            if (prev_ar_wait) check_value("araddr_hold", prev_araddr, araddr);
            if (prev_aw_wait) check_value("awaddr_hold", prev_awaddr, awaddr);
            if (prev_w_wait) check_value("wdata_hold", prev_wdata, wdata);
            if (prev_w_wait) check_value("wstrb_hold", prev_wstrb, wstrb);
            prev_ar_wait = arvalid && !arready;
            prev_aw_wait = awvalid && !awready;
            prev_w_wait = wvalid && !wready;
            prev_araddr = araddr;
            prev_awaddr = awaddr;
            prev_wdata = wdata;
            prev_wstrb = wstrb;
        end
    end

    initial begin
        aclk = 1'b0;
        reset = 1'b1;
        stall_en = 1'b0;
        inst_req = 1'b0;
        inst_addr = '0;
        data_req = 1'b0;
        data_wr = 1'b0;
        data_addr = '0;
        data_wdata = '0;
        data_wstrb = '0;
        errors = 0;
        checks = 0;
        tests = 0;
        test_errors = 0;
        for (int i = 0; i < 256; i++) begin
            exp_mem[i] = word_t'(i * 4) ^ FILL_PATTERN;
        end
        repeat (16) @(posedge aclk);
        #1;
        reset = 1'b0;
        test_reset_state();
        report_test("reset_state");
        test_fetch();
        report_test("fetch");
        test_store_load();
        report_test("store_load");
        test_contention();
        report_test("contention");
        test_back_pressure();
        report_test("back_pressure");
        $display("tests %0d  checks %0d  errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
